//--- core_pkg.sv
/*
 * core package
 * bridge address map, widths, PLL reconfig tables and the
 * modifier byte layout shared by the control shell
 */
`default_nettype none

package core_pkg;

    ////////////////////////////////////////
    // bridge bus
    localparam int BRIDGE_AW = 32;
    localparam int BRIDGE_DW = 32;
    localparam int REGION_W  = 8;   // top address byte picks the region

    localparam logic [BRIDGE_AW-1:0] ADDR_RESET  = {REGION_W'('hF0), (BRIDGE_AW-REGION_W)'(0)};
    localparam logic [BRIDGE_AW-1:0] ADDR_DIP    = {REGION_W'('hF1), (BRIDGE_AW-REGION_W)'(0)};
    localparam logic [BRIDGE_AW-1:0] ADDR_MOD    = {REGION_W'('hF2), (BRIDGE_AW-REGION_W)'(0)};
    localparam logic [BRIDGE_AW-1:0] ADDR_STATUS = {REGION_W'('hFA), (BRIDGE_AW-REGION_W)'(0)};

    ////////////////////////////////////////
    // switches and player inputs
    localparam int SW_W     = 8;
    localparam int PLAYER_W = 8;
    localparam int KEY_W    = 16;   // pocket controller key bitmap

    ////////////////////////////////////////
    // PLL management bus
    localparam int PLL_AW          = 6;
    localparam int PLL_DW          = 32;
    localparam int PLL_PARAM_COUNT = 9;

    typedef struct packed {
        logic [PLL_AW-1:0] addr;
        logic [PLL_DW-1:0] data;
    } pll_entry_t;

    // 57 Hz video timing
    localparam pll_entry_t PLL_57HZ [PLL_PARAM_COUNT] = '{
        '{6'h00, 32'h0000_0000},  // waitrequest mode
        '{6'h04, 32'h0000_4040},  // M counter
        '{6'h03, 32'h0002_0605},  // N counter
        '{6'h05, 32'h0002_0504},  // C0
        '{6'h05, 32'h0004_0909},  // C1
        '{6'h05, 32'h0008_4848},  // C2
        '{6'h05, 32'h000C_4848},  // C3
        '{6'h08, 32'h0000_0002},  // bandwidth
        '{6'h02, 32'h0000_0000}   // start reconfig
    };

    // 60 Hz, only M, N and bandwidth differ
    localparam pll_entry_t PLL_60HZ [PLL_PARAM_COUNT] = '{
        '{6'h00, 32'h0000_0000},
        '{6'h04, 32'h0000_4F4F},
        '{6'h03, 32'h0002_0706},
        '{6'h05, 32'h0002_0504},
        '{6'h05, 32'h0004_0909},
        '{6'h05, 32'h0008_4848},
        '{6'h05, 32'h000C_4848},
        '{6'h08, 32'h0000_0003},
        '{6'h02, 32'h0000_0000}
    };

    ////////////////////////////////////////
    // modifier byte
    typedef enum logic {
        VIDEO_57HZ = 1'b0,
        VIDEO_60HZ = 1'b1
    } video_timing_t;

    // host sees raw, the sequencer reads the fields
    typedef union packed {
        logic [SW_W-1:0] raw;
        struct packed {
            logic [4:0]    rsvd;    // unused by the shell
            video_timing_t timing;  // bit 2
            logic [1:0]    game;    // passed to the game as is
        } f;
    } mod_word_u;

endpackage

`default_nettype wire

//--- settings_if.sv
/*
 * host settings interface
 * decoded switch levels, one writer (bridge_regs) and any number of readers
 */
`timescale 1ns/10ps
`default_nettype none

interface settings_if import core_pkg::*; ();

    logic            reset_sw;  // holds the game in reset
    logic [SW_W-1:0] dip_sw0;
    logic [SW_W-1:0] dip_sw1;
    mod_word_u       mod_sw;    // modifier byte, timing select in bit 2

    // register block owns every level
    modport regs (
        output reset_sw,
        output dip_sw0,
        output dip_sw1,
        output mod_sw
    );

    // consumers only look
    modport user (
        input reset_sw,
        input dip_sw0,
        input dip_sw1,
        input mod_sw
    );

endinterface

`default_nettype wire

//--- bridge_regs.sv
/*
 * bridge register block
 * decodes host writes into the settings registers and
 * muxes readback and the status word onto the bridge read data
 */
`timescale 1ns/10ps
`default_nettype none

module bridge_regs import core_pkg::*; (
    input  logic                 clk_74a,
    input  logic                 rst_n,
    // host bridge
    input  logic [BRIDGE_AW-1:0] bridge_addr,
    input  logic                 bridge_wr,
    input  logic [BRIDGE_DW-1:0] bridge_wr_data,
    output logic [BRIDGE_DW-1:0] bridge_rd_data,
    // status from the PLL sequencer
    input  logic                 reconfig_pause,
    input  logic                 init_locked,
    input  video_timing_t        timing_active,
    // decoded settings out
    settings_if.regs             settings
);

    // status word layout
    localparam int STAT_LOCK_BIT  = 0;
    localparam int STAT_PAUSE_BIT = 1;
    localparam int STAT_TIME_BIT  = 2;

    logic [BRIDGE_DW-1:0] status_word;

    ////////////////////////////////////////
    // write side
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            settings.reset_sw <= 1'b0;
            settings.dip_sw0  <= '0;
            settings.dip_sw1  <= '0;
            settings.mod_sw   <= '0;  // timing field decodes as 57 Hz
        end else if (bridge_wr) begin
            case (bridge_addr)  // full 32-bit match, no aliasing
                ADDR_RESET: settings.reset_sw <= bridge_wr_data[0];
                ADDR_DIP: begin
                    settings.dip_sw0 <= bridge_wr_data[SW_W-1:0];
                    settings.dip_sw1 <= bridge_wr_data[2*SW_W-1:SW_W];
                end
                ADDR_MOD:   settings.mod_sw.raw <= bridge_wr_data[SW_W-1:0];
                default: ;  // writes elsewhere belong to other blocks
            endcase
        end
    end

    ////////////////////////////////////////
    // read side

    // sequencer state as the host sees it
    always_comb begin
        status_word                 = '0;
        status_word[STAT_LOCK_BIT]  = init_locked;
        status_word[STAT_PAUSE_BIT] = reconfig_pause;
        status_word[STAT_TIME_BIT]  = timing_active;
    end

    // combinational on the address, no read strobe
    always_comb begin
        case (bridge_addr)
            ADDR_RESET:  bridge_rd_data = BRIDGE_DW'(settings.reset_sw);
            ADDR_DIP:    bridge_rd_data = BRIDGE_DW'({settings.dip_sw1, settings.dip_sw0});
            ADDR_MOD:    bridge_rd_data = BRIDGE_DW'(settings.mod_sw.raw);
            ADDR_STATUS: bridge_rd_data = status_word;
            default:     bridge_rd_data = '0;
        endcase
    end

    ////////////////////////////////////////
    // checks

    // host must hold a defined address whenever it strobes a write
    a_wr_addr_known: assert property (
        @(posedge clk_74a) disable iff (!rst_n)
        bridge_wr |-> !$isunknown(bridge_addr)
    ) else $error("bridge write with unknown address");

endmodule

`default_nettype wire

//--- pll_reconfig.sv
/*
 * PLL reconfiguration sequencer
 * on a change of the modifier timing bit, pauses the game, lets it settle,
 * then streams the matching parameter table onto the PLL management bus
 */
`timescale 1ns/10ps
`default_nettype none

module pll_reconfig import core_pkg::*; #(
    parameter int SETTLE_W = 8  // settle time is about 2^SETTLE_W enabled cycles
) (
    input  logic              clk_74a,
    input  logic              rst_n,
    settings_if.user          settings,
    // PLL management bus
    input  logic              pll_locked,
    input  logic              pll_waitrequest,
    output logic              pll_cfg_write,
    output logic [PLL_AW-1:0] pll_cfg_address,
    output logic [PLL_DW-1:0] pll_cfg_data,
    // status
    output logic              reconfig_pause,
    output logic              init_locked,
    output video_timing_t     timing_active
);

    localparam int IDX_W = $clog2(PLL_PARAM_COUNT);

    logic                mgmt_en;       // PLL can take a write this cycle
    video_timing_t       timing_req;    // what the host asked for
    video_timing_t       timing_lat;    // what the running sequence loads
    logic [SETTLE_W-1:0] settle_cnt;    // 0 idle, counting, all ones writes
    logic [IDX_W-1:0]    param_idx;
    logic                settle_done;
    logic                last_entry;
    pll_entry_t          entry;

    assign mgmt_en     = pll_locked & ~pll_waitrequest;
    assign timing_req  = settings.mod_sw.f.timing;
    assign settle_done = &settle_cnt;
    assign last_entry  = (param_idx == IDX_W'(PLL_PARAM_COUNT - 1));

    // table entry for the latched timing
    always_comb begin
        if (timing_lat == VIDEO_60HZ) begin
            entry = PLL_60HZ[param_idx];
        end else begin
            entry = PLL_57HZ[param_idx];
        end
    end

    ////////////////////////////////////////
    // sequencer
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            pll_cfg_write  <= 1'b0;
            reconfig_pause <= 1'b0;
            init_locked    <= 1'b0;
            timing_lat     <= VIDEO_57HZ;   // PLL powers up at 57 Hz
            timing_active  <= VIDEO_57HZ;
            settle_cnt     <= '0;
            param_idx      <= '0;
        end else begin
            pll_cfg_write <= 1'b0;          // single cycle strobe

            // everything freezes while the PLL stalls us
            if (mgmt_en) begin
                init_locked <= 1'b1;

                if (settle_done) begin
                    // one table entry per enabled cycle
                    pll_cfg_write   <= 1'b1;
                    pll_cfg_address <= entry.addr;
                    pll_cfg_data    <= entry.data;
                    param_idx       <= param_idx + IDX_W'(1);
                    if (last_entry) begin
                        settle_cnt    <= '0;
                        param_idx     <= '0;
                        timing_active <= timing_lat;  // start reconfig just went out
                    end
                end else if (|settle_cnt) begin
                    settle_cnt <= settle_cnt + SETTLE_W'(1);  // settling
                end else if (timing_req != timing_lat) begin
                    // new timing, a change made mid sequence waits until here
                    timing_lat     <= timing_req;
                    settle_cnt     <= SETTLE_W'(1);
                    reconfig_pause <= 1'b1;
                    param_idx      <= '0;
                end else begin
                    reconfig_pause <= 1'b0;   // idle, let the game run
                end
            end
        end
    end

    ////////////////////////////////////////
    // checks

    // a strobe comes from a cycle where the PLL was ready
    a_no_write_in_wait: assert property (
        @(posedge clk_74a) disable iff (!rst_n)
        pll_cfg_write |-> $past(pll_locked && !pll_waitrequest)
    ) else $error("PLL write issued while wait-request was high");

    a_idx_in_range: assert property (
        @(posedge clk_74a) disable iff (!rst_n)
        param_idx < IDX_W'(PLL_PARAM_COUNT)
    ) else $error("PLL table index out of range");

endmodule

`default_nettype wire

//--- core_control.sv
/*
 * game control
 * maps pocket controller keys onto the two active low player bytes
 * and builds the game pause and reset levels
 */
`timescale 1ns/10ps
`default_nettype none

module core_control import core_pkg::*; (
    input  logic                clk_74a,
    input  logic                rst_n,
    settings_if.user            settings,
    input  logic [KEY_W-1:0]    cont1_key,
    input  logic [KEY_W-1:0]    cont2_key,
    input  logic                osnotify_inmenu,  // OS menu open
    input  logic                reconfig_pause,
    input  logic                init_locked,
    output logic [PLAYER_W-1:0] player1,
    output logic [PLAYER_W-1:0] player2,
    output logic                game_pause,
    output logic                game_reset
);

    // pocket key bitmap positions
    localparam int KEY_UP     = 0;
    localparam int KEY_DOWN   = 1;
    localparam int KEY_LEFT   = 2;
    localparam int KEY_RIGHT  = 3;
    localparam int KEY_FACE_A = 4;
    localparam int KEY_FACE_B = 5;
    localparam int KEY_SELECT = 14;  // coin
    localparam int KEY_START  = 15;

    // buttons and stick of one player, arcade order, still active high
    function automatic logic [5:0] stick_bits(input logic [KEY_W-1:0] key);
        stick_bits = {key[KEY_FACE_B], key[KEY_FACE_A],
                      key[KEY_DOWN], key[KEY_UP],
                      key[KEY_LEFT], key[KEY_RIGHT]};
    endfunction

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            player1    <= '1;    // nothing pressed
            player2    <= '1;
            game_pause <= 1'b0;
            game_reset <= 1'b1;  // held until the PLL first locks
        end else begin
            // starts for both players ride on player1
            player1    <= ~{cont2_key[KEY_START], cont1_key[KEY_START],
                            stick_bits(cont1_key)};
            // coins on player2
            player2    <= ~{cont2_key[KEY_SELECT], cont1_key[KEY_SELECT],
                            stick_bits(cont2_key)};
            game_pause <= osnotify_inmenu | reconfig_pause;
            game_reset <= settings.reset_sw | ~init_locked;
        end
    end

endmodule

`default_nettype wire

//--- core_top.sv
/*
 * control shell top level
 * host settings registers, PLL reconfig sequencer and game control
 * on clk_74a, plain ports toward the bridge, the PLL and the game core
 */
`timescale 1ns/10ps
`default_nettype none

module core_top import core_pkg::*; #(
    parameter int SETTLE_W = 8
) (
    input  logic                 clk_74a,
    input  logic                 rst_n,
    // host bridge
    input  logic [BRIDGE_AW-1:0] bridge_addr,
    input  logic                 bridge_wr,
    input  logic [BRIDGE_DW-1:0] bridge_wr_data,
    output logic [BRIDGE_DW-1:0] bridge_rd_data,
    input  logic                 osnotify_inmenu,
    // controllers
    input  logic [KEY_W-1:0]     cont1_key,
    input  logic [KEY_W-1:0]     cont2_key,
    // PLL management bus
    input  logic                 pll_locked,
    input  logic                 pll_waitrequest,
    output logic                 pll_cfg_write,
    output logic [PLL_AW-1:0]    pll_cfg_address,
    output logic [PLL_DW-1:0]    pll_cfg_data,
    // toward the game core
    output logic [SW_W-1:0]      dip_sw0,
    output logic [SW_W-1:0]      dip_sw1,
    output logic [PLAYER_W-1:0]  player1,
    output logic [PLAYER_W-1:0]  player2,
    output logic                 game_pause,
    output logic                 game_reset
);

    settings_if settings ();

    logic          reconfig_pause;
    logic          init_locked;
    video_timing_t timing_active;

    // DIP bytes go straight to the game
    assign dip_sw0 = settings.dip_sw0;
    assign dip_sw1 = settings.dip_sw1;

    ////////////////////////////////////////
    // register block, sole settings writer
    bridge_regs u_bridge_regs (
        .clk_74a        (clk_74a),
        .rst_n          (rst_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .reconfig_pause (reconfig_pause),
        .init_locked    (init_locked),
        .timing_active  (timing_active),
        .settings       (settings.regs)
    );

    ////////////////////////////////////////
    // PLL sequencer
    pll_reconfig #(
        .SETTLE_W (SETTLE_W)
    ) u_pll_reconfig (
        .clk_74a         (clk_74a),
        .rst_n           (rst_n),
        .settings        (settings.user),
        .pll_locked      (pll_locked),
        .pll_waitrequest (pll_waitrequest),
        .pll_cfg_write   (pll_cfg_write),
        .pll_cfg_address (pll_cfg_address),
        .pll_cfg_data    (pll_cfg_data),
        .reconfig_pause  (reconfig_pause),
        .init_locked     (init_locked),
        .timing_active   (timing_active)
    );

    ////////////////////////////////////////
    // inputs, pause, reset
    core_control u_core_control (
        .clk_74a         (clk_74a),
        .rst_n           (rst_n),
        .settings        (settings.user),
        .cont1_key       (cont1_key),
        .cont2_key       (cont2_key),
        .osnotify_inmenu (osnotify_inmenu),
        .reconfig_pause  (reconfig_pause),
        .init_locked     (init_locked),
        .player1         (player1),
        .player2         (player2),
        .game_pause      (game_pause),
        .game_reset      (game_reset)
    );

endmodule

`default_nettype wire

//--- tb_core_top.sv
/*
 * control shell testbench
 * directed tests over the bridge registers, player mapping, pause merge
 * and PLL reconfiguration against a random wait-request PLL model
 */
`timescale 1ns/10ps
`default_nettype none

module tb_core_top import core_pkg::*; ();

    localparam int SETTLE_W    = 4;
    localparam int CLK_HALF    = 2;     // 4 ns period
    localparam int N_TESTS     = 6;
    // one sequence in enabled cycles, stalls at most triple it
    localparam int SEQ_WORST   = 3 * (2**SETTLE_W + PLL_PARAM_COUNT + 4);
    localparam int TEST_BUDGET = 100;   // reads, writes, polling overhead
    localparam int CYCLE_LIMIT = N_TESTS * TEST_BUDGET + 2 * SEQ_WORST;

    logic                 clk_74a;
    logic                 rst_n;
    logic [BRIDGE_AW-1:0] bridge_addr;
    logic                 bridge_wr;
    logic [BRIDGE_DW-1:0] bridge_wr_data;
    logic [BRIDGE_DW-1:0] bridge_rd_data;
    logic                 osnotify_inmenu;
    logic [KEY_W-1:0]     cont1_key;
    logic [KEY_W-1:0]     cont2_key;
    logic                 pll_locked;
    logic                 pll_waitrequest = 1'b0;
    logic                 pll_cfg_write;
    logic [PLL_AW-1:0]    pll_cfg_address;
    logic [PLL_DW-1:0]    pll_cfg_data;
    logic [SW_W-1:0]      dip_sw0;
    logic [SW_W-1:0]      dip_sw1;
    logic [PLAYER_W-1:0]  player1;
    logic [PLAYER_W-1:0]  player2;
    logic                 game_pause;
    logic                 game_reset;

    int   errors    = 0;
    int   checks    = 0;
    int   tests_run = 0;
    int   cycle_cnt = 0;
    logic wait_rand;            // PLL model stalls at random
    int   wait_run  = 0;        // consecutive stall cycles
    logic wait_last = 1'b0;     // wait-request of the previous cycle
    logic [PLL_AW-1:0] wr_addr_q [$];
    logic [PLL_DW-1:0] wr_data_q [$];

    core_top #(
        .SETTLE_W (SETTLE_W)
    ) UUT (
        .clk_74a         (clk_74a),
        .rst_n           (rst_n),
        .bridge_addr     (bridge_addr),
        .bridge_wr       (bridge_wr),
        .bridge_wr_data  (bridge_wr_data),
        .bridge_rd_data  (bridge_rd_data),
        .osnotify_inmenu (osnotify_inmenu),
        .cont1_key       (cont1_key),
        .cont2_key       (cont2_key),
        .pll_locked      (pll_locked),
        .pll_waitrequest (pll_waitrequest),
        .pll_cfg_write   (pll_cfg_write),
        .pll_cfg_address (pll_cfg_address),
        .pll_cfg_data    (pll_cfg_data),
        .dip_sw0         (dip_sw0),
        .dip_sw1         (dip_sw1),
        .player1         (player1),
        .player2         (player2),
        .game_pause      (game_pause),
        .game_reset      (game_reset)
    );

    initial begin
        clk_74a = 1'b0;
        forever #CLK_HALF clk_74a = ~clk_74a;
    end

    ////////////////////////////////////////
    // PLL model

    // stall bursts capped at two cycles
    always @(posedge clk_74a) begin
        if (wait_rand && wait_run < 2 && ($urandom % 3) == 0) begin
            pll_waitrequest <= 1'b1;
            wait_run        <= wait_run + 1;
        end else begin
            pll_waitrequest <= 1'b0;
            wait_run        <= 0;
        end
    end

    // log cfg writes, strobe is registered so look one cycle back
    always @(negedge clk_74a) begin
        if (rst_n && pll_cfg_write) begin
            check_eq(32'(wait_last), 32'd0, "cfg write issued from a wait-request cycle");
            check_eq(32'(game_pause), 32'd1, "game_pause during cfg write");
            wr_addr_q.push_back(pll_cfg_address);
            wr_data_q.push_back(pll_cfg_data);
        end
        wait_last = pll_waitrequest;
    end

    // run limit
    always @(posedge clk_74a) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("ERROR: run did not finish within %0d cycles, stopped", cycle_cnt);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // helpers

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %-14s ok", name);
        end else begin
            $display("test %-14s %0d mismatches", name, errors - errs_before);
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk_74a);
        bridge_addr    <= addr;
        bridge_wr      <= 1'b1;
        bridge_wr_data <= data;
        @(posedge clk_74a);
        bridge_wr      <= 1'b0;     // register took it on this edge
    endtask

    // read data is combinational, sample mid cycle
    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk_74a);
        bridge_addr <= addr;
        @(negedge clk_74a);
        data = bridge_rd_data;
    endtask

    // pocket keys: up 0, down 1, left 2, right 3, a 4, b 5, select 14, start 15
    function automatic logic [7:0] model_player1(input logic [15:0] k1, input logic [15:0] k2);
        return ~{k2[15], k1[15], k1[5], k1[4], k1[1], k1[0], k1[2], k1[3]};
    endfunction

    // coins on top, then player two stick
    function automatic logic [7:0] model_player2(input logic [15:0] k1, input logic [15:0] k2);
        return ~{k2[14], k1[14], k2[5], k2[4], k2[1], k2[0], k2[2], k2[3]};
    endfunction

    ////////////////////////////////////////
    // tests

    task automatic test_after_reset();
        int          e0;
        logic [31:0] st;
        e0 = errors;
        @(negedge clk_74a);
        check_eq(32'(pll_cfg_write), 32'd0, "cfg_write after reset");
        check_eq(32'(game_pause), 32'd0, "game_pause after reset");
        check_eq(32'(game_reset), 32'd1, "game_reset after reset");
        st = '0;
        while (!st[0]) begin
            bus_read(ADDR_STATUS, st);
            check_eq(32'(game_reset), 32'd1, "game_reset held until lock seen");
        end
        check_eq(32'(st[2:1]), 32'd0, "status timing 57 Hz, no pause");
        @(negedge clk_74a);
        check_eq(32'(game_reset), 32'd0, "game_reset one cycle after lock");
        report_test("after_reset", e0);
    endtask

    task automatic test_registers();
        int          e0;
        logic [31:0] d;
        logic [31:0] rd;
        logic [31:0] bad;
        e0 = errors;
        d = $urandom;
        bus_write(ADDR_DIP, d);
        bus_read(ADDR_DIP, rd);
        check_eq(rd, {16'h0, d[15:0]}, "DIP readback");
        check_eq(32'(dip_sw0), 32'(d[7:0]), "dip_sw0 port");
        check_eq(32'(dip_sw1), 32'(d[15:8]), "dip_sw1 port");
        d = $urandom & ~32'h4;      // timing stays 57 Hz
        bus_write(ADDR_MOD, d);
        bus_read(ADDR_MOD, rd);
        check_eq(rd, {24'h0, d[7:0]}, "modifier readback");
        bus_write(ADDR_RESET, $urandom | 32'h1);
        bus_read(ADDR_RESET, rd);
        check_eq(rd, 32'h1, "reset_sw readback set");
        check_eq(32'(game_reset), 32'd1, "game_reset from reset_sw");
        bus_write(ADDR_RESET, $urandom & ~32'h1);
        bus_read(ADDR_RESET, rd);
        check_eq(rd, 32'h0, "reset_sw readback clear");
        check_eq(32'(game_reset), 32'd0, "game_reset released");
        bad = ADDR_STATUS | {8'h0, 24'($urandom | 1)};  // low bits never zero
        bus_read(bad, rd);
        check_eq(rd, 32'h0, "unmapped address reads zero");
        report_test("registers", e0);
    endtask

    task automatic test_player_map();
        int          e0;
        int          i;
        logic [15:0] k1;
        logic [15:0] k2;
        logic [7:0]  p1_old;
        logic [7:0]  p2_old;
        e0     = errors;
        p1_old = model_player1(cont1_key, cont2_key);
        p2_old = model_player2(cont1_key, cont2_key);
        for (i = 0; i < 8; i++) begin
            k1 = 16'($urandom);
            k2 = 16'($urandom);
            @(posedge clk_74a);
            cont1_key <= k1;
            cont2_key <= k2;
            @(negedge clk_74a);
            check_eq(32'(player1), 32'(p1_old), "player1 before its edge");
            check_eq(32'(player2), 32'(p2_old), "player2 before its edge");
            @(negedge clk_74a);
            p1_old = model_player1(k1, k2);
            p2_old = model_player2(k1, k2);
            check_eq(32'(player1), 32'(p1_old), "player1 mapping");
            check_eq(32'(player2), 32'(p2_old), "player2 mapping");
        end
        report_test("player_map", e0);
    endtask

    task automatic test_pause_menu();
        int e0;
        e0 = errors;
        @(posedge clk_74a);
        osnotify_inmenu <= 1'b1;
        @(negedge clk_74a);
        check_eq(32'(game_pause), 32'd0, "game_pause before menu edge");
        @(negedge clk_74a);
        check_eq(32'(game_pause), 32'd1, "game_pause with menu open");
        @(posedge clk_74a);
        osnotify_inmenu <= 1'b0;
        @(negedge clk_74a);
        @(negedge clk_74a);
        check_eq(32'(game_pause), 32'd0, "game_pause with menu closed");
        report_test("pause_menu", e0);
    endtask

    // switch timing, expect the matching table under random stalls
    task automatic run_reconfig(input video_timing_t t, input string name);
        int          e0;
        int          i;
        logic [31:0] d;
        logic [31:0] st;
        pll_entry_t  exp_tab [PLL_PARAM_COUNT];
        e0 = errors;
        if (t == VIDEO_60HZ) begin
            exp_tab = PLL_60HZ;
        end else begin
            exp_tab = PLL_57HZ;
        end
        wr_addr_q.delete();
        wr_data_q.delete();
        @(posedge clk_74a);
        wait_rand <= 1'b1;
        d = ($urandom & 32'hFB) | (32'(t) << 2);
        bus_write(ADDR_MOD, d);
        st = '0;
        while (!st[1]) begin
            bus_read(ADDR_STATUS, st);
        end
        check_eq(32'(st[2]), 32'(t == VIDEO_57HZ), "old timing while settling");
        check_eq(32'(wr_addr_q.size()), 32'd0, "no cfg write before settle");
        @(negedge clk_74a);
        check_eq(32'(game_pause), 32'd1, "game_pause from reconfig pause");
        while (st[1]) begin
            bus_read(ADDR_STATUS, st);     // done when pause falls
        end
        check_eq(32'(st[2]), 32'(t), "new timing after pause fell");
        @(posedge clk_74a);
        wait_rand <= 1'b0;
        check_eq(32'(wr_addr_q.size()), 32'(PLL_PARAM_COUNT), "cfg write count");
        for (i = 0; i < wr_addr_q.size() && i < PLL_PARAM_COUNT; i++) begin
            check_eq(32'(wr_addr_q[i]), 32'(exp_tab[i].addr), $sformatf("cfg address %0d", i));
            check_eq(wr_data_q[i], exp_tab[i].data, $sformatf("cfg data %0d", i));
        end
        @(negedge clk_74a);
        check_eq(32'(game_pause), 32'd0, "game_pause after reconfig");
        report_test(name, e0);
    endtask

    ////////////////////////////////////////
    // main sequence
    initial begin
        void'($urandom(35530));
        rst_n           = 1'b0;
        bridge_addr     = '0;
        bridge_wr       = 1'b0;
        bridge_wr_data  = '0;
        osnotify_inmenu = 1'b0;
        cont1_key       = '0;
        cont2_key       = '0;
        pll_locked      = 1'b1;     // PLL always locked here
        wait_rand       = 1'b0;
        repeat (2) @(posedge clk_74a);
        rst_n <= 1'b1;

        test_after_reset();
        test_registers();
        test_player_map();
        test_pause_menu();
        run_reconfig(VIDEO_60HZ, "reconfig_60hz");
        run_reconfig(VIDEO_57HZ, "reconfig_57hz");

        $display("tests %0d, checks %0d, mismatches %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- pocket_core_shell.f
core_pkg.sv
settings_if.sv
bridge_regs.sv
pll_reconfig.sv
core_control.sv
core_top.sv
tb_core_top.sv

//--- Makefile
# Verilator build and run of the control shell testbench

VERILATOR ?= verilator
TOP       ?= tb_core_top
FILELIST  ?= pocket_core_shell.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
SOURCES   ?= $(wildcard *.sv)

EXE = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(EXE): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

test: $(EXE)
	./$(EXE) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "run ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
